//--- logic/capture_pkg.sv
package capture_pkg;

	// one adc stream beat and one buffer word
	localparam int sample_w = 32;

	// buffer words, power of two
	localparam int capt_depth = 256;

	// buffer address width, log2 of capt_depth
	localparam int capt_aw = 8;

	// count field, holds 0 up to capt_depth inclusive
	localparam int cnt_w = 9;

	// capture engine states
	// cap_idle   nothing armed, stream not ready
	// cap_armed  waiting for the next beat, holding register empty
	// cap_write  beat held, buffer write requested
	// cap_done   length reached or tlast seen
	typedef enum logic [1:0] {
		cap_idle,
		cap_armed,
		cap_write,
		cap_done
	} cap_state_e;

endpackage

//--- logic/regmap_pkg.sv
package regmap_pkg;

	// apb byte address width
	localparam int apb_aw = 12;

	// register offsets, word aligned
	typedef enum logic [apb_aw-1:0] {
		reg_ctrl   = 12'h000,
		reg_resetn = 12'h004,
		reg_len    = 12'h008,
		reg_status = 12'h00C
	} reg_addr_e;

	// buffer read window
	// word i at win_base + 4*i
	localparam logic [apb_aw-1:0] win_base = 12'h800;

	// status register layout
	localparam int st_done_bit = 0;
	localparam int st_last_bit = 1;
	// low bit of the count field
	localparam int st_cnt_lsb = 16;

endpackage

//--- logic/capture_bram.sv
module capture_bram (
	input  logic                              clk_adc2,
	input  logic                              en,
	input  logic                              we,
	input  logic [capture_pkg::capt_aw-1:0]   addr,
	input  logic [capture_pkg::sample_w-1:0]  din,
	output logic [capture_pkg::sample_w-1:0]  dout
);
	import capture_pkg::*;

	// sample storage
	logic [sample_w-1:0] mem [capt_depth];

	// single port, write or registered read per cycle
	always_ff @(posedge clk_adc2) begin
		if (en) begin
			if (we) begin
				mem[addr] <= din;
			end else begin
				// word shows on dout next cycle
				dout <= mem[addr];
			end
		end
	end

endmodule

//--- logic/bram_arbiter.sv
module bram_arbiter (
	input  logic                              clk_adc2,
	input  logic                              rst_n,
	// capture writer side
	input  logic                              wr_req,
	input  logic [capture_pkg::capt_aw-1:0]   wr_addr,
	input  logic [capture_pkg::sample_w-1:0]  wr_data,
	output logic                              wr_gnt,
	// host reader side
	input  logic                              rd_req,
	input  logic [capture_pkg::capt_aw-1:0]   rd_addr,
	output logic                              rd_gnt,
	// buffer port
	output logic                              en,
	output logic                              we,
	output logic [capture_pkg::capt_aw-1:0]   addr,
	output logic [capture_pkg::sample_w-1:0]  din
);

	// set when the writer won the last granted cycle
	logic last_wr;

	// writer wins when alone, or on a tie if the reader went last
	assign wr_gnt = wr_req & (~rd_req | ~last_wr);
	// reader takes whatever the writer did not
	assign rd_gnt = rd_req & ~wr_gnt;

	// granted access hits the buffer this same cycle
	assign en = wr_gnt | rd_gnt;
	assign we = wr_gnt;

	// steer winner address onto the port
	assign addr = wr_gnt ? wr_addr : rd_addr;
	// only the writer has data, ignored on reads
	assign din = wr_data;

	// remember the winner for the next tie
	always_ff @(posedge clk_adc2) begin
		if (!rst_n) begin
			last_wr <= 1'b0;
		end else if (wr_gnt | rd_gnt) begin
			last_wr <= wr_gnt;
		end
	end

endmodule

//--- logic/adc_capture.sv
module adc_capture (
	input  logic                              clk_adc2,
	input  logic                              rst_n,
	// control from the register block
	input  logic                              cap_rst_n,
	input  logic                              arm,
	input  logic [capture_pkg::cnt_w-1:0]     capt_len,
	// adc stream slave
	input  logic                              s_tvalid,
	output logic                              s_tready,
	input  logic [capture_pkg::sample_w-1:0]  s_tdata,
	input  logic                              s_tlast,
	// buffer write request
	output logic                              wr_req,
	output logic [capture_pkg::capt_aw-1:0]   wr_addr,
	output logic [capture_pkg::sample_w-1:0]  wr_data,
	input  logic                              wr_gnt,
	// status back to the register block
	output logic                              done,
	output logic                              last_seen,
	output logic [capture_pkg::cnt_w-1:0]     count
);
	import capture_pkg::*;

	cap_state_e          state;
	// one-beat holding register
	logic [sample_w-1:0] hold_data;
	logic                hold_last;
	logic [cnt_w-1:0]    count_nxt;

	// holding register is only full in cap_write
	assign s_tready = (state == cap_armed);

	// held beat goes to the word at the current count
	assign wr_req  = (state == cap_write);
	assign wr_addr = count[capt_aw-1:0];
	assign wr_data = hold_data;

	assign count_nxt = count + 1'b1;

	// beat capture, payload only
	always_ff @(posedge clk_adc2) begin
		if (s_tvalid && s_tready) begin
			hold_data <= s_tdata;
			hold_last <= s_tlast;
		end
	end

	// engine fsm
	always_ff @(posedge clk_adc2) begin
		if (!rst_n || !cap_rst_n) begin
			// soft reset leaves the buffer contents alone
			state     <= cap_idle;
			count     <= '0;
			done      <= 1'b0;
			last_seen <= 1'b0;
		end else begin
			case (state)
				cap_write: begin
					// wait for the arbiter, req stays up meanwhile
					if (wr_gnt) begin
						count <= count_nxt;
						if (count_nxt >= capt_len || hold_last) begin
							state     <= cap_done;
							done      <= 1'b1;
							last_seen <= hold_last;
						end else begin
							state <= cap_armed;
						end
					end
				end
				default: begin
					// restart from word zero
					if (arm) begin
						state     <= cap_armed;
						count     <= '0;
						done      <= 1'b0;
						last_seen <= 1'b0;
					end else if (state == cap_armed && s_tvalid) begin
						state <= cap_write;
					end
				end
			endcase
		end
	end

endmodule

//--- logic/apb_regs.sv
module apb_regs (
	input  logic                              clk_adc2,
	input  logic                              rst_n,
	// apb slave
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [regmap_pkg::apb_aw-1:0]     paddr,
	input  logic [31:0]                       pwdata,
	output logic [31:0]                       prdata,
	output logic                              pready,
	output logic                              pslverr,
	// capture engine control
	output logic                              arm,
	output logic                              cap_rst_n,
	output logic [capture_pkg::cnt_w-1:0]     capt_len,
	// capture engine status
	input  logic                              done,
	input  logic                              last_seen,
	input  logic [capture_pkg::cnt_w-1:0]     count,
	// buffer read port via the arbiter
	output logic                              rd_req,
	output logic [capture_pkg::capt_aw-1:0]   rd_addr,
	input  logic                              rd_gnt,
	input  logic [capture_pkg::sample_w-1:0]  rd_data
);
	import capture_pkg::*;
	import regmap_pkg::*;

	// window read sequencing
	typedef enum logic {
		win_wait,
		win_data
	} win_state_e;

	win_state_e        win_state;
	logic              acc;
	logic              win_sel;
	logic [apb_aw-1:0] win_off;
	logic [apb_aw-3:0] win_idx;
	logic              win_oob;
	logic              win_rd_ok;
	logic              reg_known;
	logic              err;
	logic [31:0]       status_word;

	// length clamped to 1..capt_depth
	function automatic logic [cnt_w-1:0] len_clamp(input logic [31:0] v);
		logic [cnt_w-1:0] r;
		if (v == 32'd0) begin
			r = 1;
		end else if (v > 32'(capt_depth)) begin
			r = cnt_w'(capt_depth);
		end else begin
			r = v[cnt_w-1:0];
		end
		return r;
	endfunction

	// access phase
	assign acc = psel & penable;

	// window decode, word index above capt_aw bits is out of range
	assign win_sel   = (paddr >= win_base);
	assign win_off   = paddr - win_base;
	assign win_idx   = win_off[apb_aw-1:2];
	assign win_oob   = |win_idx[apb_aw-3:capt_aw];
	assign win_rd_ok = win_sel & ~pwrite & ~win_oob;

	always_comb begin
		case (paddr)
			reg_ctrl, reg_resetn, reg_len, reg_status: reg_known = 1'b1;
			default: reg_known = 1'b0;
		endcase
	end

	// status is read only, window is read only
	assign err = win_sel ? (pwrite | win_oob)
		: (~reg_known | (pwrite & (paddr == reg_status)));

	// registers and errors finish at once, window waits for data
	assign pready  = acc & (win_rd_ok ? (win_state == win_data) : 1'b1);
	assign pslverr = acc & err;

	// request held until the arbiter grants
	assign rd_req  = acc & win_rd_ok & (win_state == win_wait);
	assign rd_addr = win_idx[capt_aw-1:0];

	always_comb begin
		status_word = '0;
		status_word[st_done_bit] = done;
		status_word[st_last_bit] = last_seen;
		status_word[st_cnt_lsb +: cnt_w] = count;
	end

	// read mux, ctrl reads back zero
	always_comb begin
		prdata = '0;
		if (win_sel) begin
			prdata = rd_data;
		end else begin
			case (paddr)
				reg_resetn: prdata[0] = cap_rst_n;
				reg_len: prdata[cnt_w-1:0] = capt_len;
				reg_status: prdata = status_word;
				default: prdata = '0;
			endcase
		end
	end

	// bram dout lands the cycle after the grant
	always_ff @(posedge clk_adc2) begin
		if (!rst_n) begin
			win_state <= win_wait;
		end else if (win_state == win_wait && rd_gnt) begin
			win_state <= win_data;
		end else if (win_state == win_data) begin
			win_state <= win_wait;
		end
	end

	// register writes, arm is a single cycle pulse
	always_ff @(posedge clk_adc2) begin
		if (!rst_n) begin
			arm       <= 1'b0;
			cap_rst_n <= 1'b1;
			capt_len  <= cnt_w'(capt_depth);
		end else begin
			arm <= 1'b0;
			if (acc && pwrite && !win_sel) begin
				case (paddr)
					reg_ctrl: arm <= pwdata[0];
					reg_resetn: cap_rst_n <= pwdata[0];
					reg_len: capt_len <= len_clamp(pwdata);
					default: ;
				endcase
			end
		end
	end

endmodule

//--- logic/capture_top.sv
module capture_top (
	input  logic                              clk_adc2,
	input  logic                              rst_n,
	// apb
	input  logic                              psel,
	input  logic                              penable,
	input  logic                              pwrite,
	input  logic [regmap_pkg::apb_aw-1:0]     paddr,
	input  logic [31:0]                       pwdata,
	output logic [31:0]                       prdata,
	output logic                              pready,
	output logic                              pslverr,
	// adc stream
	input  logic                              s_tvalid,
	output logic                              s_tready,
	input  logic [capture_pkg::sample_w-1:0]  s_tdata,
	input  logic                              s_tlast
);
	import capture_pkg::*;

	// register block to engine
	logic                arm;
	logic                cap_rst_n;
	logic [cnt_w-1:0]    capt_len;
	logic                done;
	logic                last_seen;
	logic [cnt_w-1:0]    count;
	// arbiter requesters
	logic                wr_req;
	logic [capt_aw-1:0]  wr_addr;
	logic [sample_w-1:0] wr_data;
	logic                wr_gnt;
	logic                rd_req;
	logic [capt_aw-1:0]  rd_addr;
	logic                rd_gnt;
	// buffer port
	logic                bram_en;
	logic                bram_we;
	logic [capt_aw-1:0]  bram_addr;
	logic [sample_w-1:0] bram_din;
	logic [sample_w-1:0] bram_dout;

	apb_regs u_regs (
		.clk_adc2(clk_adc2), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.arm(arm), .cap_rst_n(cap_rst_n), .capt_len(capt_len),
		.done(done), .last_seen(last_seen), .count(count),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_gnt(rd_gnt), .rd_data(bram_dout)
	);

	adc_capture u_capture (
		.clk_adc2(clk_adc2), .rst_n(rst_n),
		.cap_rst_n(cap_rst_n), .arm(arm), .capt_len(capt_len),
		.s_tvalid(s_tvalid), .s_tready(s_tready), .s_tdata(s_tdata), .s_tlast(s_tlast),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_gnt(wr_gnt),
		.done(done), .last_seen(last_seen), .count(count)
	);

	// writer and host reader share the one port
	bram_arbiter u_arb (
		.clk_adc2(clk_adc2), .rst_n(rst_n),
		.wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_gnt(wr_gnt),
		.rd_req(rd_req), .rd_addr(rd_addr), .rd_gnt(rd_gnt),
		.en(bram_en), .we(bram_we), .addr(bram_addr), .din(bram_din)
	);

	capture_bram u_bram (
		.clk_adc2(clk_adc2),
		.en(bram_en), .we(bram_we), .addr(bram_addr),
		.din(bram_din), .dout(bram_dout)
	);

endmodule

//--- sim/tb_clock.sv
module tb_clock (
	output logic clk_adc2
);

	// half of the 40 unit period
	localparam int half_period = 20;

	// free running, starts low
	initial begin
		clk_adc2 = 1'b0;
		forever begin
			#half_period;
			clk_adc2 = ~clk_adc2;
		end
	end

endmodule

//--- sim/capture_tb.sv
module capture_tb;
	import capture_pkg::*;
	import regmap_pkg::*;

	localparam int clk_period = 40;
	// total beats over all tests sets the watchdog length
	localparam int planned_beats = 103;
	localparam longint wd_cycles = longint'(planned_beats) * 200 + 1000;

	logic                clk_adc2;
	logic                rst_n;
	logic                psel;
	logic                penable;
	logic                pwrite;
	logic [apb_aw-1:0]   paddr;
	logic [31:0]         pwdata;
	logic [31:0]         prdata;
	logic                pready;
	logic                pslverr;
	logic                s_tvalid;
	logic                s_tready;
	logic [sample_w-1:0] s_tdata;
	logic                s_tlast;

	// expected words for every buffer entry the tests wrote
	logic [sample_w-1:0] model [capt_depth];
	integer              seed;
	int                  checks;
	int                  errors;
	int                  fails;
	int                  acc_cnt;
	int                  len_vals [5] = '{0, 1, 40, 300, 256};
	// pending compares for the compare process
	logic [31:0]         act_q [$];
	logic [31:0]         exp_q [$];
	string               what_q [$];

	tb_clock u_clk (.clk_adc2(clk_adc2));

	capture_top u_dut (
		.clk_adc2(clk_adc2), .rst_n(rst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.s_tvalid(s_tvalid), .s_tready(s_tready), .s_tdata(s_tdata), .s_tlast(s_tlast)
	);

	// status word the capture rules predict
	function automatic logic [31:0] exp_status(input int len, input int sent,
			input int tlast_pos);
		int          n;
		logic        lst;
		logic [31:0] w;
		n = (sent < len) ? sent : len;
		lst = 1'b0;
		// tlast ends the capture early
		if (tlast_pos > 0 && tlast_pos <= n) begin
			n = tlast_pos;
			lst = 1'b1;
		end
		w = '0;
		w[st_done_bit] = lst | (n == len);
		w[st_last_bit] = lst;
		w[st_cnt_lsb +: cnt_w] = cnt_w'(n);
		return w;
	endfunction

	// length register range is 1 to depth
	function automatic logic [31:0] exp_len(input logic [31:0] v);
		if (v == 32'd0) begin
			return 32'd1;
		end
		if (v > 32'(capt_depth)) begin
			return 32'(capt_depth);
		end
		return v;
	endfunction

	task automatic check_eq(input logic [31:0] act, input logic [31:0] exp,
			input string what);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("ERROR %0t: %s, got %h expected %h", $time, what, act, exp);
		end
	endtask

	task automatic expect_eq(input logic [31:0] act, input logic [31:0] exp,
			input string what);
		act_q.push_back(act);
		exp_q.push_back(exp);
		what_q.push_back(what);
	endtask

	// compare process
	always @(posedge clk_adc2) begin
		while (exp_q.size() > 0) begin
			check_eq(act_q.pop_front(), exp_q.pop_front(), what_q.pop_front());
		end
	end

	// counts every handshake on the stream
	always @(posedge clk_adc2) begin
		if (rst_n && s_tvalid && s_tready) begin
			acc_cnt++;
		end
	end

	// drive point shortly after the rising edge
	task automatic next_cycle();
		@(posedge clk_adc2);
		#5;
	endtask

	// setup then access phase
	// pready, prdata and pslverr sampled at the falling edge
	task automatic apb_xfer(input logic wr, input logic [apb_aw-1:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int   n;
		logic win_rd;
		// in-range window reads wait for the buffer
		win_rd = !wr && addr >= win_base && 32'(addr - win_base) < 32'(4 * capt_depth);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		next_cycle();
		penable = 1'b1;
		n = 0;
		@(negedge clk_adc2);
		while (!pready && n < 20) begin
			@(negedge clk_adc2);
			n++;
		end
		if (!pready) begin
			fails++;
			$display("apb transfer to %h never saw pready", addr);
		end else if (win_rd) begin
			// data the cycle after the grant, one lost tie at most
			expect_eq(32'(n >= 1 && n <= 2), 32'd1,
				$sformatf("window read latency at %h", addr));
		end else begin
			// registers and error responses have no wait states
			expect_eq(32'(n), 32'd0, $sformatf("wait states at %h", addr));
		end
		rdata = prdata;
		err = pslverr;
		next_cycle();
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic read_check(input logic [apb_aw-1:0] addr, input logic [31:0] exp,
			input string what);
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b0, addr, 32'd0, rd, err);
		expect_eq(rd, exp, what);
		expect_eq({31'b0, err}, 32'd0, {what, " pslverr"});
	endtask

	task automatic write_ok(input logic [apb_aw-1:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic        err;
		apb_xfer(1'b1, addr, data, rd, err);
		expect_eq({31'b0, err}, 32'd0, $sformatf("pslverr on write to %h", addr));
	endtask

	task automatic err_check(input logic wr, input logic [apb_aw-1:0] addr, input string what);
		logic [31:0] rd;
		logic        err;
		apb_xfer(wr, addr, 32'd0, rd, err);
		expect_eq({31'b0, err}, 32'd1, what);
	endtask

	task automatic arm_capture(input int len);
		write_ok(reg_len, 32'(len));
		write_ok(reg_ctrl, 32'd1);
	endtask

	// random gap then hold the beat until the engine takes it
	task automatic send_beat(input int idx, input logic last);
		int                  gap;
		int                  n;
		logic [sample_w-1:0] d;
		gap = {$random(seed)} % 4;
		repeat (gap) next_cycle();
		d = $random(seed);
		s_tvalid = 1'b1;
		s_tdata = d;
		s_tlast = last;
		n = 0;
		while (!s_tready && n < 50) begin
			next_cycle();
			n++;
		end
		if (!s_tready) begin
			fails++;
			$display("stream beat %0d was never accepted", idx);
		end else begin
			// taken at this edge
			next_cycle();
			model[idx] = d;
		end
		s_tvalid = 1'b0;
		s_tlast = 1'b0;
	endtask

	// poll status until done or the poll limit
	task automatic wait_done();
		logic [31:0] st;
		logic        err;
		int          n;
		n = 0;
		st = '0;
		while (!st[st_done_bit] && n < 200) begin
			apb_xfer(1'b0, reg_status, 32'd0, st, err);
			n++;
		end
		if (!st[st_done_bit]) begin
			fails++;
			$display("capture never reported done, engine in %s",
				u_dut.u_capture.state.name());
		end
	endtask

	task automatic check_window(input int lo, input int hi);
		for (int i = lo; i < hi; i++) begin
			read_check(win_base + apb_aw'(4 * i), model[i], $sformatf("window word %0d", i));
		end
	endtask

	// offers one more beat that must be refused
	task automatic blocked_beat(input string what);
		int base;
		base = acc_cnt;
		s_tvalid = 1'b1;
		repeat (6) begin
			expect_eq({31'b0, s_tready}, 32'd0, {what, " s_tready"});
			next_cycle();
		end
		s_tvalid = 1'b0;
		expect_eq(32'(acc_cnt - base), 32'd0, {what, " extra beat taken"});
	endtask

	initial begin
		int base;
		seed = 32'h4389;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		s_tvalid = 1'b0;
		s_tdata = '0;
		s_tlast = 1'b0;
		repeat (2) @(posedge clk_adc2);
		#5;
		rst_n = 1'b1;

		// reset values
		read_check(reg_resetn, 32'd1, "resetn after reset");
		read_check(reg_len, 32'd256, "len after reset");
		read_check(reg_status, 32'd0, "status after reset");
		expect_eq({31'b0, s_tready}, 32'd0, "s_tready after reset");

		// length clamp then error responses
		foreach (len_vals[k]) begin
			write_ok(reg_len, 32'(len_vals[k]));
			read_check(reg_len, exp_len(32'(len_vals[k])),
				$sformatf("len %0d", len_vals[k]));
		end
		err_check(1'b0, 12'h010, "unmapped offset");
		err_check(1'b1, reg_status, "status write");
		err_check(1'b0, win_base + 12'h400, "window word 256");
		err_check(1'b0, 12'hFFC, "window top");
		err_check(1'b1, win_base, "window write");

		// length 40 with gaps
		arm_capture(40);
		base = acc_cnt;
		for (int i = 0; i < 40; i++) begin
			send_beat(i, 1'b0);
		end
		wait_done();
		read_check(reg_status, exp_status(40, 40, 0), "status len 40");
		expect_eq(32'(acc_cnt - base), 32'd40, "beats taken len 40");
		blocked_beat("after len 40");
		check_window(0, 40);

		// tlast on beat 17 of 64
		arm_capture(64);
		for (int i = 0; i < 17; i++) begin
			send_beat(i, i == 16);
		end
		wait_done();
		read_check(reg_status, exp_status(64, 17, 17), "status tlast");
		check_window(0, 40);

		// host reads above the capture while it runs
		arm_capture(16);
		fork
			begin
				for (int i = 0; i < 16; i++) begin
					send_beat(i, 1'b0);
				end
			end
			check_window(16, 40);
		join
		wait_done();
		read_check(reg_status, exp_status(16, 16, 0), "status with reads");
		check_window(0, 16);

		// soft reset in the middle of a capture
		arm_capture(50);
		for (int i = 0; i < 10; i++) begin
			send_beat(i, 1'b0);
		end
		write_ok(reg_resetn, 32'd0);
		repeat (2) next_cycle();
		read_check(reg_status, 32'd0, "status in soft reset");
		blocked_beat("in soft reset");
		write_ok(reg_resetn, 32'd1);
		read_check(reg_resetn, 32'd1, "resetn released");
		arm_capture(20);
		for (int i = 0; i < 20; i++) begin
			send_beat(i, 1'b0);
		end
		wait_done();
		read_check(reg_status, exp_status(20, 20, 0), "status after soft reset");
		check_window(0, 40);

		// let the compare process drain
		repeat (2) next_cycle();
		$display("checks %0d, mismatches %0d, other failures %0d", checks, errors, fails);
		if (errors == 0 && fails == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(wd_cycles * clk_period);
		$display("watchdog ran out after %0d cycles, the run did not finish", wd_cycles);
		$display("** FAIL **");
		$finish;
	end

endmodule

//--- tb.f
logic/capture_pkg.sv
logic/regmap_pkg.sv
logic/capture_bram.sv
logic/bram_arbiter.sv
logic/adc_capture.sv
logic/apb_regs.sv
logic/capture_top.sv
sim/tb_clock.sv
sim/capture_tb.sv

//--- Makefile
TOP := capture_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TOP) -f tb.f

# pass only when the log holds the pass line
run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

lint:
	verilator --lint-only --timing --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log
